// File: logic/soc_bus_pkg.sv
/* Wishbone B4 bus widths, cycle-type encoding and the request and response structs */

`default_nettype none

package soc_bus_pkg;

  // ==========================================================
  // Widths
  // ==========================================================

  // Byte address and bus word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One select bit per byte lane
  typedef logic [3:0] sel_t;

  // Main RAM line of 16 bytes and its byte strobes
  typedef logic [127:0] line_t;
  typedef logic [15:0]  line_strb_t;

  localparam int unsigned WORDS_PER_LINE = 4;

  // ==========================================================
  // Cycle type and bus structs
  // ==========================================================

  // Registered feedback cycle types in use
  typedef enum logic [2:0] {
    WB_CTI_CLASSIC = 3'b000,
    WB_CTI_INCR    = 3'b010,
    WB_CTI_EOB     = 3'b111
  } wb_cti_e;

  // Master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    addr_t   adr;
    data_t   dat;
    sel_t    sel;
    wb_cti_e cti;
  } wb_req_t;

  // Slave to master, no stall or retry
  typedef struct packed {
    data_t dat;
    logic  ack;
    logic  err;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: logic/soc_map_pkg.sv
/* SoC memory map bases and masks, CLINT register offsets, region enum */

`default_nettype none

package soc_map_pkg;

  // ==========================================================
  // Region bases and masks
  // ==========================================================

  // Regions decode on address bits 31:28
  localparam soc_bus_pkg::addr_t RAM_BASE   = 32'h8000_0000;
  localparam soc_bus_pkg::addr_t RAM_MASK   = 32'hF000_0000;
  localparam soc_bus_pkg::addr_t CLINT_BASE = 32'h3000_0000;
  localparam soc_bus_pkg::addr_t CLINT_MASK = 32'hF000_0000;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_CLINT,
    REGION_NONE
  } region_e;

  // ==========================================================
  // CLINT registers
  // ==========================================================

  // Offsets inside the CLINT window
  typedef logic [15:0] clint_ofs_t;

  // 64 bit timer registers
  typedef logic [63:0] mtime_t;

  localparam clint_ofs_t CLINT_MSIP_OFS        = 16'h0000;
  localparam clint_ofs_t CLINT_MTIMECMP_OFS    = 16'h4000;
  localparam clint_ofs_t CLINT_MTIMECMP_HI_OFS = CLINT_MTIMECMP_OFS + 16'h0004;
  localparam clint_ofs_t CLINT_MTIME_OFS       = 16'hBFF8;
  localparam clint_ofs_t CLINT_MTIME_HI_OFS    = CLINT_MTIME_OFS + 16'h0004;

endpackage

`default_nettype wire

// File: logic/line_ram.sv
/* Line-wide RAM with byte-strobe writes and a registered read port */

`timescale 1ns/1ps
`default_nettype none

module line_ram #(
  parameter int unsigned DEPTH_LINES = 1024
) (
  input  logic                           clk_i,
  input  logic [$clog2(DEPTH_LINES)-1:0] addr_i,
  input  logic [127:0]                   wdata_i,
  input  logic [15:0]                    wstrb_i,
  input  logic                           rd_en_i,
  output logic [127:0]                   rdata_o
);

  // Bytes per line, one strobe each
  localparam int unsigned LINE_BYTES = 16;

  logic [8*LINE_BYTES-1:0] mem_q [DEPTH_LINES];

  // ==========================================================
  // Write port
  // ==========================================================

  // Only strobed bytes change
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (wstrb_i[b]) begin
        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // ==========================================================
  // Read port
  // ==========================================================

  // Line held until the next read enable
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: logic/wb_region_decoder.sv
/* Wishbone address decoder with request fan-out, response return
   and an error response for unmapped addresses */

`timescale 1ns/1ps
`default_nettype none

module wb_region_decoder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t m_req_i,
  output soc_bus_pkg::wb_rsp_t m_rsp_o,
  output soc_bus_pkg::wb_req_t ram_req_o,
  output soc_bus_pkg::wb_req_t clint_req_o,
  input  soc_bus_pkg::wb_rsp_t ram_rsp_i,
  input  soc_bus_pkg::wb_rsp_t clint_rsp_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  region_e region;
  logic    m_active;
  logic    err_q;

  assign m_active = m_req_i.cyc & m_req_i.stb;

  // ==========================================================
  // Region decode
  // ==========================================================

  always_comb begin
    if ((m_req_i.adr & RAM_MASK) == RAM_BASE) begin
      region = REGION_RAM;
    end else if ((m_req_i.adr & CLINT_MASK) == CLINT_BASE) begin
      region = REGION_CLINT;
    end else begin
      region = REGION_NONE;
    end
  end

  // Fields go to both slaves, stb only to the addressed one
  always_comb begin
    ram_req_o       = m_req_i;
    clint_req_o     = m_req_i;
    ram_req_o.stb   = m_req_i.stb && (region == REGION_RAM);
    clint_req_o.stb = m_req_i.stb && (region == REGION_CLINT);
  end

  // ==========================================================
  // Unmapped error
  // ==========================================================

  // One cycle after stb, then drops as the master takes it
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= m_active && (region == REGION_NONE) && !err_q;
    end
  end

  // Response of the selected slave only
  always_comb begin
    m_rsp_o = '0;
    case (region)
      REGION_RAM: begin
        m_rsp_o.dat = ram_rsp_i.dat;
        m_rsp_o.ack = ram_rsp_i.ack;
        m_rsp_o.err = ram_rsp_i.err;
      end
      REGION_CLINT: begin
        m_rsp_o.dat = clint_rsp_i.dat;
        m_rsp_o.ack = clint_rsp_i.ack;
        m_rsp_o.err = clint_rsp_i.err;
      end
      default: begin
        // No slave behind this address
        m_rsp_o.err = err_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/wb_ram_adapter.sv
/* Wishbone to line RAM adapter with write expansion, read latency
   pipeline and a line buffer for incrementing bursts */

`timescale 1ns/1ps
`default_nettype none

module wb_ram_adapter #(
  parameter int unsigned RAM_SIZE_KB = 16,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);
  import soc_bus_pkg::*;

  localparam int unsigned LINE_BYTES  = $bits(line_strb_t);
  localparam int unsigned DEPTH_LINES = (RAM_SIZE_KB * 1024) / LINE_BYTES;
  localparam int unsigned LINE_IDX_W  = $clog2(DEPTH_LINES);
  localparam int unsigned LINE_OFS_W  = $clog2(LINE_BYTES);
  localparam int unsigned WORD_IDX_W  = $clog2(WORDS_PER_LINE);
  localparam int unsigned WORD_W      = $bits(data_t);
  localparam int unsigned SEL_W       = $bits(sel_t);

  logic                  req;
  logic                  wr_req;
  logic                  rd_req;
  logic                  rd_en;
  logic                  busy;
  logic                  read_done;
  logic                  buf_hit;
  logic [LINE_IDX_W-1:0] line_idx;
  logic [WORD_IDX_W-1:0] word_idx;
  line_t                 wdata_line;
  line_strb_t            wstrb_line;
  line_t                 ram_rdata;

  // Read tracking
  logic                   pending_q;
  logic [RAM_LATENCY-1:0] delay_q;
  logic [RAM_LATENCY:0]   delay_shift;

  // Burst buffer
  logic  buf_valid_q;
  line_t buf_line_q;

  assign req      = req_i.cyc & req_i.stb;
  assign wr_req   = req & req_i.we;
  assign rd_req   = req & ~req_i.we;
  assign line_idx = req_i.adr[LINE_OFS_W +: LINE_IDX_W];
  assign word_idx = req_i.adr[LINE_OFS_W-1:2];

  // ==========================================================
  // Write expansion
  // ==========================================================

  // Word copied to every slot, strobes pick the addressed one
  always_comb begin
    wdata_line = '0;
    wstrb_line = '0;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      wdata_line[w*WORD_W +: WORD_W] = req_i.dat;
    end
    if (wr_req) begin
      wstrb_line[word_idx*SEL_W +: SEL_W] = req_i.sel;
    end
  end

  // ==========================================================
  // Read path
  // ==========================================================

  // One RAM read per access, none while a line is buffered
  assign busy    = pending_q | (|delay_q);
  assign rd_en   = rd_req & ~buf_valid_q & ~busy;
  assign buf_hit = rd_req & buf_valid_q;

  // Last stage marks the line ready
  assign delay_shift = {delay_q, pending_q};
  assign read_done   = delay_q[RAM_LATENCY-1];

  line_ram #(
    .DEPTH_LINES (DEPTH_LINES)
  ) i_line_ram (
    .clk_i   (clk_i),
    .addr_i  (line_idx),
    .wdata_i (wdata_line),
    .wstrb_i (wstrb_line),
    .rd_en_i (rd_en),
    .rdata_o (ram_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      delay_q     <= '0;
      buf_valid_q <= 1'b0;
    end else begin
      pending_q <= rd_en;
      delay_q   <= delay_shift[RAM_LATENCY-1:0];
      if (read_done) begin
        // Keep the line only when more beats follow
        buf_valid_q <= rd_req && (req_i.cti == WB_CTI_INCR);
      end else if (buf_hit && (req_i.cti != WB_CTI_INCR)) begin
        buf_valid_q <= 1'b0;
      end else if (wr_req) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Line capture on the first beat
  always_ff @(posedge clk_i) begin
    if (read_done) begin
      buf_line_q <= ram_rdata;
    end
  end

  // ==========================================================
  // Response
  // ==========================================================

  // Writes and buffered beats ack at once
  always_comb begin
    if (buf_valid_q) begin
      rsp_o.dat = buf_line_q[word_idx*WORD_W +: WORD_W];
    end else begin
      rsp_o.dat = ram_rdata[word_idx*WORD_W +: WORD_W];
    end
    rsp_o.ack = wr_req | read_done | buf_hit;
    rsp_o.err = 1'b0;
  end

endmodule

`default_nettype wire

// File: logic/wb_clint.sv
/* Core-local interruptor with mtime, mtimecmp and msip registers
   and the timer and software interrupt outputs */

`timescale 1ns/1ps
`default_nettype none

module wb_clint (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t rsp_o,
  output logic                 timer_irq_o,
  output logic                 sw_irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  clint_ofs_t ofs;
  logic       access;
  data_t      rdata_d;

  mtime_t mtime_q;
  mtime_t mtimecmp_q;
  logic   msip_q;
  logic   ack_q;
  logic   timer_irq_q;
  data_t  rdata_q;

  // Byte lanes merged into an existing word
  function automatic data_t apply_sel(data_t old_w, data_t new_w, sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < $bits(sel_t); b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign ofs = req_i.adr[15:0];

  // Registered ack blocks a second ack on the same stb
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // ==========================================================
  // Registers
  // ==========================================================

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      ack_q       <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      mtime_q     <= mtime_q + 64'd1;
      ack_q       <= access;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      if (access && req_i.we) begin
        case (ofs)
          CLINT_MSIP_OFS: begin
            if (req_i.sel[0]) begin
              msip_q <= req_i.dat[0];
            end
          end
          CLINT_MTIMECMP_OFS: begin
            mtimecmp_q[31:0] <= apply_sel(mtimecmp_q[31:0], req_i.dat, req_i.sel);
          end
          CLINT_MTIMECMP_HI_OFS: begin
            mtimecmp_q[63:32] <= apply_sel(mtimecmp_q[63:32], req_i.dat, req_i.sel);
          end
          default: begin
            // mtime is read only
          end
        endcase
      end
    end
  end

  // ==========================================================
  // Read data and outputs
  // ==========================================================

  // Unknown offsets read as zero
  always_comb begin
    case (ofs)
      CLINT_MSIP_OFS:        rdata_d = {31'd0, msip_q};
      CLINT_MTIMECMP_OFS:    rdata_d = mtimecmp_q[31:0];
      CLINT_MTIMECMP_HI_OFS: rdata_d = mtimecmp_q[63:32];
      CLINT_MTIME_OFS:       rdata_d = mtime_q[31:0];
      CLINT_MTIME_HI_OFS:    rdata_d = mtime_q[63:32];
      default:               rdata_d = '0;
    endcase
  end

  // Sampled with the access, shown with the ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.dat   = rdata_q;
  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = 1'b0;
  assign timer_irq_o = timer_irq_q;
  assign sw_irq_o    = msip_q;

endmodule

`default_nettype wire

// File: logic/soc_fabric_top.sv
/* Wishbone slave fabric top with region decoder, RAM adapter and CLINT */

`timescale 1ns/1ps
`default_nettype none

module soc_fabric_top #(
  parameter int unsigned RAM_SIZE_KB = 16,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t wb_req_i,
  output soc_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                 timer_irq_o,
  output logic                 sw_irq_o
);
  import soc_bus_pkg::*;

  // Per-slave request and response
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t clint_req;
  wb_rsp_t clint_rsp;

  // ==========================================================
  // Decoder
  // ==========================================================

  wb_region_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .m_req_i     (wb_req_i),
    .m_rsp_o     (wb_rsp_o),
    .ram_req_o   (ram_req),
    .clint_req_o (clint_req),
    .ram_rsp_i   (ram_rsp),
    .clint_rsp_i (clint_rsp)
  );

  // ==========================================================
  // Slaves
  // ==========================================================

  // Main RAM at 0x8000_0000
  wb_ram_adapter #(
    .RAM_SIZE_KB (RAM_SIZE_KB),
    .RAM_LATENCY (RAM_LATENCY)
  ) i_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (ram_req),
    .rsp_o  (ram_rsp)
  );

  // CLINT at 0x3000_0000
  wb_clint i_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (clint_req),
    .rsp_o       (clint_rsp),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

endmodule

`default_nettype wire

// File: testbench/soc_fabric_properties.sv
/* Concurrent checks on the top-level Wishbone port, bound to the fabric top */

`timescale 1ns/1ps
`default_nettype none

module soc_fabric_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input soc_bus_pkg::wb_req_t wb_req_i,
  input soc_bus_pkg::wb_rsp_t wb_rsp_o
);

  // ==========================================================
  // Response rules
  // ==========================================================

  // One kind of termination per beat
  a_ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp_o.ack && wb_rsp_o.err))
    else $error("ack and err high in the same cycle");

  // Terminations only inside an active strobe
  a_rsp_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_rsp_o.ack || wb_rsp_o.err) |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("ack or err without cyc and stb");

  // ==========================================================
  // Master rules
  // ==========================================================

  // Open beat keeps every request field
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack && !wb_rsp_o.err)
    |=> $stable(wb_req_i))
    else $error("request changed before ack or err");

endmodule

bind soc_fabric_top soc_fabric_properties i_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .wb_req_i (wb_req_i),
  .wb_rsp_o (wb_rsp_o)
);

`default_nettype wire

// File: testbench/soc_fabric_tb.sv
/* Fabric testbench with clock, reset, LFSR stimulus, checker, timeout
   and directed tests for RAM, bursts, CLINT and unmapped access */

`timescale 1ns/1ps
`default_nettype none

module soc_fabric_tb;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int unsigned RAM_SIZE_KB    = 16;
  localparam int unsigned RAM_LATENCY    = 4;
  localparam int unsigned RAM_WORDS      = RAM_SIZE_KB * 256;
  localparam int unsigned LINE_IDX_W     = $clog2(RAM_SIZE_KB * 1024 / 16);
  // All tests take about 500 cycles
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] LFSR_SEED      = 32'he26d489e;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

  logic        clk_i;
  logic        rst_ni;
  wb_req_t     req;
  wb_rsp_t     rsp;
  logic        timer_irq;
  logic        sw_irq;
  logic [31:0] lfsr_q;
  int unsigned cycle_cnt;
  int unsigned ack_cycle;
  logic [31:0] last_burst_line;

  // Reference RAM contents, one entry per word
  data_t       model_mem [RAM_WORDS];
  data_t       burst_data [WORDS_PER_LINE];
  int unsigned burst_lat [WORDS_PER_LINE];

  soc_fabric_top #(
    .RAM_SIZE_KB (RAM_SIZE_KB),
    .RAM_LATENCY (RAM_LATENCY)
  ) dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_req_i    (req),
    .wb_rsp_o    (rsp),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq)
  );

  // ==========================================================
  // Clock, timeout and helpers
  // ==========================================================

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic addr_t ram_addr(input logic [31:0] line, input logic [31:0] word);
    return RAM_BASE + (line << 4) + (word << 2);
  endfunction

  function automatic int unsigned model_index(input addr_t adr);
    return (adr - RAM_BASE) >> 2;
  endfunction

  // Byte-select rule of the bus
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "Check mismatch");
    end
  endtask

  // ==========================================================
  // Bus master
  // ==========================================================

  // Counts negedges until ack or err, request already on the bus
  task automatic wait_response(output data_t rdata, output int unsigned lat,
                               output logic ack, output logic err);
    lat = 0;
    @(negedge clk_i);
    while (!(rsp.ack || rsp.err)) begin
      lat++;
      @(negedge clk_i);
    end
    rdata     = rsp.dat;
    ack       = rsp.ack;
    err       = rsp.err;
    ack_cycle = cycle_cnt;
  endtask

  task automatic wb_access(input logic we, input addr_t adr, input data_t dat, input sel_t sel,
                           output data_t rdata, output int unsigned lat,
                           output logic ack, output logic err);
    wb_req_t r;
    r     = '0;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = we;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    @(posedge clk_i);
    req <= r;
    wait_response(rdata, lat, ack, err);
    @(posedge clk_i);
    req <= '0;
  endtask

  task automatic wb_write(input addr_t adr, input data_t dat, input sel_t sel,
                          output int unsigned lat);
    data_t rdata;
    logic  ack;
    logic  err;
    wb_access(1'b1, adr, dat, sel, rdata, lat, ack, err);
    check_eq(ack, 1'b1, "ack on write");
  endtask

  task automatic wb_read(input addr_t adr, output data_t rdata, output int unsigned lat);
    logic ack;
    logic err;
    wb_access(1'b0, adr, '0, 4'hF, rdata, lat, ack, err);
    check_eq(ack, 1'b1, "ack on read");
  endtask

  // INCR beats then EOB, adr moves after each ack
  task automatic wb_burst_read(input addr_t line_base);
    wb_req_t     r;
    data_t       d;
    int unsigned lat;
    logic        ack;
    logic        err;
    r     = '0;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.sel = 4'hF;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      r.adr = line_base + (i << 2);
      r.cti = (i == WORDS_PER_LINE - 1) ? WB_CTI_EOB : WB_CTI_INCR;
      @(posedge clk_i);
      req <= r;
      wait_response(d, lat, ack, err);
      check_eq(ack, 1'b1, "ack on burst beat");
      burst_data[i] = d;
      burst_lat[i]  = lat;
    end
    @(posedge clk_i);
    req <= '0;
  endtask

  // RAM write mirrored into the model
  task automatic ram_store(input addr_t adr, input data_t dat, input sel_t sel);
    int unsigned lat;
    wb_write(adr, dat, sel, lat);
    check_eq(lat, 0, "RAM write ack latency");
    model_mem[model_index(adr)] = merge_bytes(model_mem[model_index(adr)], dat, sel);
  endtask

  task automatic ram_load_check(input addr_t adr);
    data_t       d;
    int unsigned lat;
    wb_read(adr, d, lat);
    check_eq(d, model_mem[model_index(adr)], "RAM read data");
    check_eq(lat, RAM_LATENCY + 1, "RAM read ack latency");
  endtask

  // First beat from RAM, later beats from the line buffer
  task automatic check_burst(input logic [31:0] line);
    wb_burst_read(ram_addr(line, 0));
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      check_eq(burst_data[w], model_mem[model_index(ram_addr(line, w))], "burst data");
      check_eq(burst_lat[w], (w == 0) ? RAM_LATENCY + 1 : 0, "burst beat latency");
    end
    last_burst_line = line;
  endtask

  task automatic clint_write(input clint_ofs_t ofs, input data_t dat);
    int unsigned lat;
    wb_write(CLINT_BASE + ofs, dat, 4'hF, lat);
    check_eq(lat, 1, "CLINT write ack latency");
  endtask

  task automatic clint_read(input clint_ofs_t ofs, output data_t d);
    int unsigned lat;
    wb_read(CLINT_BASE + ofs, d, lat);
    check_eq(lat, 1, "CLINT read ack latency");
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================

  task automatic test_ram_masked;
    logic [31:0] lines [4];
    logic [31:0] line;
    logic [31:0] word;
    sel_t        sel;
    for (int k = 0; k < 4; k++) begin
      lines[k] = rand_bits(LINE_IDX_W);
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        ram_store(ram_addr(lines[k], w), rand_bits(32), 4'hF);
      end
    end
    // Single-byte overwrites
    for (int k = 0; k < 8; k++) begin
      line = lines[rand_bits(2)];
      word = rand_bits(2);
      sel  = 4'b0001 << rand_bits(2);
      ram_store(ram_addr(line, word), rand_bits(32), sel);
    end
    for (int k = 0; k < 4; k++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        ram_load_check(ram_addr(lines[k], w));
      end
    end
  endtask

  task automatic test_burst_read;
    logic [31:0] line;
    addr_t       other;
    line  = rand_bits(LINE_IDX_W);
    other = ram_addr(line ^ 32'd1, 2);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      ram_store(ram_addr(line, w), rand_bits(32), 4'hF);
    end
    ram_store(other, rand_bits(32), 4'hF);
    check_burst(line);
    // Another line, so stale buffer data would show
    ram_load_check(other);
  endtask

  task automatic test_read_after_write;
    logic [31:0] line_a;
    logic [31:0] line_b;
    line_a = last_burst_line;
    line_b = line_a ^ 32'd2;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      ram_store(ram_addr(line_b, w), rand_bits(32), 4'hF);
    end
    check_burst(line_a);
    // No write in between, only EOB frees the buffer
    check_burst(line_b);
  endtask

  task automatic test_clint_msip_mtime;
    data_t       d;
    data_t       m1;
    data_t       m2;
    int unsigned t1;
    int unsigned t2;
    check_eq(sw_irq, 1'b0, "sw_irq after reset");
    clint_write(CLINT_MSIP_OFS, 32'h1);
    check_eq(sw_irq, 1'b1, "sw_irq after msip set");
    clint_read(CLINT_MSIP_OFS, d);
    check_eq(d, 32'h1, "msip readback");
    clint_write(CLINT_MSIP_OFS, 32'h0);
    check_eq(sw_irq, 1'b0, "sw_irq after msip clear");
    clint_read(CLINT_MTIME_OFS, m1);
    t1 = ack_cycle;
    repeat (7) @(posedge clk_i);
    clint_read(CLINT_MTIME_OFS, m2);
    t2 = ack_cycle;
    check_eq((m2 - m1) >= (t2 - t1), 1'b1, "mtime advance between reads");
    clint_read(CLINT_MTIME_HI_OFS, d);
    check_eq(d, 32'h0, "mtime high word");
  endtask

  task automatic test_timer_irq;
    data_t       m;
    int unsigned waited;
    check_eq(timer_irq, 1'b0, "timer_irq after reset");
    clint_read(CLINT_MTIME_OFS, m);
    clint_write(CLINT_MTIMECMP_OFS, m + 32'd50);
    clint_write(CLINT_MTIMECMP_HI_OFS, 32'h0);
    @(negedge clk_i);
    check_eq(timer_irq, 1'b0, "timer_irq before compare match");
    waited = 0;
    while (!timer_irq && (waited < 60)) begin
      @(negedge clk_i);
      waited++;
    end
    check_eq(timer_irq, 1'b1, "timer_irq within 60 cycles");
    // High word first keeps the compare far away
    clint_write(CLINT_MTIMECMP_HI_OFS, 32'hFFFF_FFFF);
    clint_write(CLINT_MTIMECMP_OFS, 32'hFFFF_FFFF);
    @(negedge clk_i);
    check_eq(timer_irq, 1'b0, "timer_irq after mtimecmp reset");
  endtask

  task automatic test_unmapped;
    data_t       d;
    int unsigned lat;
    logic        ack;
    logic        err;
    wb_access(1'b0, 32'h1000_0000, '0, 4'hF, d, lat, ack, err);
    check_eq({ack, err}, 2'b01, "unmapped read response");
    check_eq(lat, 1, "unmapped read err latency");
    wb_access(1'b1, 32'h1000_0004, 32'hDEAD_BEEF, 4'hF, d, lat, ack, err);
    check_eq({ack, err}, 2'b01, "unmapped write response");
    check_eq(lat, 1, "unmapped write err latency");
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    req       = '0;
    lfsr_q    = LFSR_SEED;
    cycle_cnt = 0;
    ack_cycle = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_ram_masked;
    test_burst_read;
    test_read_after_write;
    test_clint_msip_mtime;
    test_timer_irq;
    test_unmapped;
    @(posedge clk_i);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/soc_bus_pkg.sv
logic/soc_map_pkg.sv
logic/line_ram.sv
logic/wb_region_decoder.sv
logic/wb_ram_adapter.sv
logic/wb_clint.sv
logic/soc_fabric_top.sv
testbench/soc_fabric_properties.sv
testbench/soc_fabric_tb.sv
